// ==== source/soc_pkg.sv ====
// Shared widths, memory map and register offsets of the APB test fabric.
// Region is the top address nibble; codes above SRAM are unmapped.
package soc_pkg;

  // --------------------------------------------------
  // Bus widths
  // --------------------------------------------------
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned AddrWidth   = 16;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned OffsetWidth = 12;

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  typedef enum logic [3:0] {
    DEBUG = 4'h0,
    ROM   = 4'h1,
    CLINT = 4'h2,
    GPIO  = 4'h3,
    SRAM  = 4'h4
  } region_e;

  // One APB address, seen whole or split into region and offset
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      region_e                region;
      logic [OffsetWidth-1:0] offset;
    } fields;
  } apb_addr_u;

  // Memory sizes
  localparam int unsigned RomWords  = 64;
  localparam logic [15:0] RomTag    = 16'hB007;
  localparam int unsigned SramWords = 256;

  // --------------------------------------------------
  // Register offsets
  // --------------------------------------------------
  // Debug unit, ctrl bit0 ndmreset, bit1 haltreq
  localparam logic [OffsetWidth-1:0] DbgCtrlOff  = 12'h000;
  localparam logic [OffsetWidth-1:0] DbgExitOff  = 12'h004;
  localparam logic [OffsetWidth-1:0] DbgDelayOff = 12'h008;

  // CLINT
  localparam logic [OffsetWidth-1:0] ClintMsipOff = 12'h000;
  localparam logic [OffsetWidth-1:0] ClintCmpOff  = 12'h004;
  localparam logic [OffsetWidth-1:0] ClintTimeOff = 12'h008;

  // Boot window before a halt request may reach the core
  localparam int unsigned DebugDelayCycles = 20;
  localparam int unsigned DelayWidth       = $clog2(DebugDelayCycles + 1);

  localparam logic [DataWidth-1:0] CmpResetValue = '1;

endpackage

// ==== source/soc_apb_ctrl.sv ====
// APB slave front end. Register targets and errors answer with no wait state,
// ROM and SRAM reads with exactly one. The master must follow APB stability rules.
`timescale 1ns/10ps

module soc_apb_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  soc_pkg::apb_addr_u               paddr_i,
  input  logic [soc_pkg::DataWidth-1:0]    pwdata_i,
  input  logic [soc_pkg::StrbWidth-1:0]    pstrb_i,
  output logic [soc_pkg::DataWidth-1:0]    prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output logic                             sel_dbg_o,
  output logic                             sel_rom_o,
  output logic                             sel_sram_o,
  output logic                             sel_clint_o,
  output logic                             wr_o,
  output logic [soc_pkg::OffsetWidth-1:0]  offset_o,
  output logic [soc_pkg::DataWidth-1:0]    wdata_o,
  output logic [soc_pkg::StrbWidth-1:0]    strb_o,
  input  logic [soc_pkg::DataWidth-1:0]    dbg_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0]    rom_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0]    sram_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0]    clint_rdata_i
);
  import soc_pkg::*;

  region_e              region_q;
  logic                 wait_q;
  logic                 access;
  logic                 first;
  logic                 mem_rd;
  logic                 err;
  logic [DataWidth-1:0] rdata_mux;

  // --------------------------------------------------
  // Region capture and wait state
  // --------------------------------------------------
  // Region is latched in the setup cycle and held for the transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      region_q <= DEBUG;
      wait_q   <= 1'b0;
    end else begin
      if (psel_i && !penable_i) begin
        region_q <= paddr_i.fields.region;
      end
      // One extra cycle for memory reads only
      wait_q <= first & mem_rd;
    end
  end

  assign access = psel_i & penable_i;
  assign first  = access & ~wait_q;
  assign mem_rd = ((region_q == ROM) || (region_q == SRAM)) & ~pwrite_i;

  always_comb begin
    case (region_q)
      DEBUG, CLINT, SRAM: err = 1'b0;
      ROM:                err = pwrite_i;
      default:            err = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  assign pready_o  = access & (wait_q | ~mem_rd);
  assign pslverr_o = access & err;

  // Target strobes, first access cycle only
  assign sel_dbg_o   = first & (region_q == DEBUG);
  assign sel_rom_o   = first & (region_q == ROM) & ~pwrite_i;
  assign sel_sram_o  = first & (region_q == SRAM);
  assign sel_clint_o = first & (region_q == CLINT);

  assign wr_o     = pwrite_i;
  assign offset_o = paddr_i.fields.offset;
  assign wdata_o  = pwdata_i;
  assign strb_o   = pstrb_i;

  always_comb begin
    case (region_q)
      DEBUG:   rdata_mux = dbg_rdata_i;
      ROM:     rdata_mux = rom_rdata_i;
      CLINT:   rdata_mux = clint_rdata_i;
      SRAM:    rdata_mux = sram_rdata_i;
      default: rdata_mux = '0;
    endcase
  end

  // Zero on writes and errors
  assign prdata_o = (pready_o && !pwrite_i && !err) ? rdata_mux : '0;

endmodule

// ==== source/soc_rom.sv ====
// Boot ROM with computed contents, one cycle read latency.
// Only offset bits 7:2 index the array; higher bits alias.
`timescale 1ns/10ps

module soc_rom (
  input  logic                            clk_i,
  input  logic                            sel_i,
  input  logic [soc_pkg::OffsetWidth-1:0] offset_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] rom_words [RomWords];
  logic [DataWidth-1:0] rdata_q;

  // --------------------------------------------------
  // Contents
  // --------------------------------------------------
  // Tag in the upper half, word index in the lower half
  for (genvar i = 0; i < RomWords; i++) begin : g_rom_word
    assign rom_words[i] = {RomTag, 16'(i)};
  end

  // --------------------------------------------------
  // Registered read
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= rom_words[offset_i[7:2]];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== source/soc_sram.sv ====
// Single-port SRAM, byte strobed writes and registered reads.
// Word index is offset bits 9:2; contents are undefined after power-up.
`timescale 1ns/10ps

module soc_sram (
  input  logic                            clk_i,
  input  logic                            sel_i,
  input  logic                            wr_i,
  input  logic [soc_pkg::OffsetWidth-1:0] offset_i,
  input  logic [soc_pkg::DataWidth-1:0]   wdata_i,
  input  logic [soc_pkg::StrbWidth-1:0]   strb_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o
);
  import soc_pkg::*;

  logic [DataWidth-1:0] mem [SramWords];
  logic [7:0]           idx;
  logic [DataWidth-1:0] rdata_q;

  assign idx = offset_i[9:2];

  // --------------------------------------------------
  // Array access
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (wr_i) begin
        // Only strobed bytes change
        for (int b = 0; b < StrbWidth; b++) begin
          if (strb_i[b]) begin
            mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  // Holds the last read word until the next read
  assign rdata_o = rdata_q;

endmodule

// ==== source/soc_clint.sv ====
// Timer block with one hart: mtime advanced by rtc_i rising edges, mtimecmp, msip.
// rtc_i is asynchronous and must stay high and low for at least 2 clock cycles.
`timescale 1ns/10ps

module soc_clint (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            ndmreset_ni,
  input  logic                            rtc_i,
  input  logic                            sel_i,
  input  logic                            wr_i,
  input  logic [soc_pkg::OffsetWidth-1:0] offset_i,
  input  logic [soc_pkg::DataWidth-1:0]   wdata_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o,
  output logic                            timer_irq_o,
  output logic                            ipi_o
);
  import soc_pkg::*;

  logic                 clint_rst_n;
  logic [1:0]           rtc_sync_q;
  logic                 rtc_prev_q;
  logic                 rtc_rise;
  logic [DataWidth-1:0] mtime_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic                 msip_q;
  logic                 wr_en;

  // Power-on reset or peripheral reset from the debug unit
  assign clint_rst_n = rst_ni & ndmreset_ni;

  // --------------------------------------------------
  // rtc tick
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge clint_rst_n) begin
    if (!clint_rst_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  assign wr_en = sel_i & wr_i;

  always_ff @(posedge clk_i or negedge clint_rst_n) begin
    if (!clint_rst_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= CmpResetValue;
      msip_q     <= 1'b0;
    end else begin
      // A bus write to mtime wins over a tick in the same cycle
      if (wr_en && offset_i == ClintTimeOff) begin
        mtime_q <= wdata_i;
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && offset_i == ClintCmpOff) begin
        mtimecmp_q <= wdata_i;
      end
      if (wr_en && offset_i == ClintMsipOff) begin
        msip_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      ClintMsipOff: rdata_o = {{(DataWidth-1){1'b0}}, msip_q};
      ClintCmpOff:  rdata_o = mtimecmp_q;
      ClintTimeOff: rdata_o = mtime_q;
      default:      rdata_o = '0;
    endcase
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

// ==== source/soc_debug_unit.sv ====
// Debug stand-in: ndmreset with a 2-flop reset generator, delayed halt request
// and exit code. Its own registers reset from rst_ni only.
`timescale 1ns/10ps

module soc_debug_unit (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            sel_i,
  input  logic                            wr_i,
  input  logic [soc_pkg::OffsetWidth-1:0] offset_i,
  input  logic [soc_pkg::DataWidth-1:0]   wdata_i,
  output logic [soc_pkg::DataWidth-1:0]   rdata_o,
  output logic                            ndmreset_no,
  output logic                            debug_req_o,
  output logic [31:0]                     exit_o
);
  import soc_pkg::*;

  logic [1:0]            ctrl_q;
  logic [31:0]           exit_q;
  logic [DelayWidth-1:0] delay_q;
  logic                  wr_en;
  logic                  rstgen_rst_n;
  logic [1:0]            rstgen_q;

  assign wr_en = sel_i & wr_i;

  // --------------------------------------------------
  // Control, exit code and boot window
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q  <= '0;
      exit_q  <= '0;
      delay_q <= DelayWidth'(DebugDelayCycles);
    end else begin
      if (wr_en && offset_i == DbgCtrlOff) begin
        ctrl_q <= wdata_i[1:0];
      end
      if (wr_en && offset_i == DbgExitOff) begin
        exit_q <= wdata_i;
      end
      // Count down once, then stay at zero
      if (delay_q != '0) begin
        delay_q <= delay_q - 1'b1;
      end
    end
  end

  // Halt request held back until the window has passed
  assign debug_req_o = ctrl_q[1] & (delay_q == '0);
  assign exit_o      = exit_q;

  always_comb begin
    case (offset_i)
      DbgCtrlOff:  rdata_o = {{(DataWidth-2){1'b0}}, ctrl_q};
      DbgExitOff:  rdata_o = exit_q;
      DbgDelayOff: rdata_o = {{(DataWidth-DelayWidth){1'b0}}, delay_q};
      default:     rdata_o = '0;
    endcase
  end

  // --------------------------------------------------
  // Peripheral reset generator
  // --------------------------------------------------
  // Asserts at once with ndmreset, releases 2 cycles after it clears
  assign rstgen_rst_n = rst_ni & ~ctrl_q[0];

  always_ff @(posedge clk_i or negedge rstgen_rst_n) begin
    if (!rstgen_rst_n) begin
      rstgen_q <= '0;
    end else begin
      rstgen_q <= {rstgen_q[0], 1'b1};
    end
  end

  assign ndmreset_no = rstgen_q[1];

endmodule

// ==== source/soc_top.sv ====
// Peripheral side of the test harness behind one APB slave port.
// Only the CLINT sits in the peripheral reset domain.
`timescale 1ns/10ps

module soc_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rtc_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  soc_pkg::apb_addr_u            paddr_i,
  input  logic [soc_pkg::DataWidth-1:0] pwdata_i,
  input  logic [soc_pkg::StrbWidth-1:0] pstrb_i,
  output logic [soc_pkg::DataWidth-1:0] prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  output logic                          timer_irq_o,
  output logic                          ipi_o,
  output logic                          debug_req_o,
  output logic [31:0]                   exit_o
);
  import soc_pkg::*;

  logic                   sel_dbg;
  logic                   sel_rom;
  logic                   sel_sram;
  logic                   sel_clint;
  logic                   wr;
  logic [OffsetWidth-1:0] offset;
  logic [DataWidth-1:0]   wdata;
  logic [StrbWidth-1:0]   strb;
  logic [DataWidth-1:0]   dbg_rdata;
  logic [DataWidth-1:0]   rom_rdata;
  logic [DataWidth-1:0]   sram_rdata;
  logic [DataWidth-1:0]   clint_rdata;
  logic                   ndmreset_n;

  soc_apb_ctrl i_apb_ctrl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .pwdata_i      ( pwdata_i    ),
    .pstrb_i       ( pstrb_i     ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   ),
    .sel_dbg_o     ( sel_dbg     ),
    .sel_rom_o     ( sel_rom     ),
    .sel_sram_o    ( sel_sram    ),
    .sel_clint_o   ( sel_clint   ),
    .wr_o          ( wr          ),
    .offset_o      ( offset      ),
    .wdata_o       ( wdata       ),
    .strb_o        ( strb        ),
    .dbg_rdata_i   ( dbg_rdata   ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata )
  );

  soc_rom i_rom (
    .clk_i    ( clk_i     ),
    .sel_i    ( sel_rom   ),
    .offset_i ( offset    ),
    .rdata_o  ( rom_rdata )
  );

  soc_sram i_sram (
    .clk_i    ( clk_i      ),
    .sel_i    ( sel_sram   ),
    .wr_i     ( wr         ),
    .offset_i ( offset     ),
    .wdata_i  ( wdata      ),
    .strb_i   ( strb       ),
    .rdata_o  ( sram_rdata )
  );

  soc_clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_ni ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .sel_i       ( sel_clint   ),
    .wr_i        ( wr          ),
    .offset_i    ( offset      ),
    .wdata_i     ( wdata       ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  soc_debug_unit i_debug_unit (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .sel_i       ( sel_dbg     ),
    .wr_i        ( wr          ),
    .offset_i    ( offset      ),
    .wdata_i     ( wdata       ),
    .rdata_o     ( dbg_rdata   ),
    .ndmreset_no ( ndmreset_n  ),
    .debug_req_o ( debug_req_o ),
    .exit_o      ( exit_o      )
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Free-running clock and a power-on reset held low for a fixed number of cycles.
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int unsigned Period      = 40,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(Period / 2) clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tests/soc_props.sv ====
// Concurrent checks on the APB response and the one-cycle target strobes.
// Bound into every soc_apb_ctrl instance.
`timescale 1ns/10ps

module soc_props (
  input logic clk_i,
  input logic rst_ni,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic sel_dbg_i,
  input logic sel_rom_i,
  input logic sel_sram_i,
  input logic sel_clint_i
);

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  a_err_with_ready : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_i |-> pready_i)
    else $error("pslverr_o high without pready_o");

  a_ready_in_access : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i |-> (psel_i && penable_i))
    else $error("pready_o high outside an access cycle");

  // --------------------------------------------------
  // Target strobes
  // --------------------------------------------------
  a_dbg_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_dbg_i |=> !sel_dbg_i)
    else $error("sel_dbg_o wider than one cycle");

  a_rom_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_rom_i |=> !sel_rom_i)
    else $error("sel_rom_o wider than one cycle");

  a_sram_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_sram_i |=> !sel_sram_i)
    else $error("sel_sram_o wider than one cycle");

  a_clint_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    sel_clint_i |=> !sel_clint_i)
    else $error("sel_clint_o wider than one cycle");

endmodule

bind soc_apb_ctrl soc_props i_props (
  .clk_i       ( clk_i       ),
  .rst_ni      ( rst_ni      ),
  .psel_i      ( psel_i      ),
  .penable_i   ( penable_i   ),
  .pready_i    ( pready_o    ),
  .pslverr_i   ( pslverr_o   ),
  .sel_dbg_i   ( sel_dbg_o   ),
  .sel_rom_i   ( sel_rom_o   ),
  .sel_sram_i  ( sel_sram_o  ),
  .sel_clint_i ( sel_clint_o )
);

// ==== tests/soc_tb.sv ====
// Table-driven APB testbench for soc_top. Entries run in table order, so the
// debug delay test comes first while the boot window is still open.
`timescale 1ns/10ps

module soc_tb;
  import soc_pkg::*;

  localparam int unsigned ClkPeriod  = 40;
  localparam int unsigned SampleDly  = ClkPeriod / 4;
  // Roughly 500 cycles of traffic, about 8x margin
  localparam int unsigned MaxCycles  = 4000;
  localparam int unsigned MaxEntries = 64;

  // Table operations
  localparam int OpWr   = 0;
  localparam int OpRd   = 1;
  localparam int OpRdNz = 2;
  localparam int OpPoll = 3;
  localparam int OpPin  = 4;
  localparam int OpRtc  = 5;

  // Pin selectors for OpPin, carried in the address column
  localparam logic [15:0] PinTimer = 16'd0;
  localparam logic [15:0] PinIpi   = 16'd1;
  localparam logic [15:0] PinDbg   = 16'd2;
  localparam logic [15:0] PinExit  = 16'd3;

  // Memory map, region in the top nibble
  localparam logic [15:0] DbgCtrl   = 16'h0000;
  localparam logic [15:0] DbgExit   = 16'h0004;
  localparam logic [15:0] DbgDelay  = 16'h0008;
  localparam logic [15:0] RomBase   = 16'h1000;
  localparam logic [15:0] ClintMsip = 16'h2000;
  localparam logic [15:0] ClintCmp  = 16'h2004;
  localparam logic [15:0] ClintTime = 16'h2008;
  localparam logic [15:0] SramBase  = 16'h4000;
  localparam logic [15:0] RomTagRef = 16'hB007;

  logic        clk;
  logic        rst_n;
  logic        rtc;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] paddr;
  logic [31:0] pwdata;
  logic [3:0]  pstrb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        timer_irq;
  logic        ipi;
  logic        debug_req;
  logic [31:0] exit_code;

  int          t_op   [MaxEntries];
  int          t_test [MaxEntries];
  logic [15:0] t_addr [MaxEntries];
  logic [31:0] t_data [MaxEntries];
  logic [3:0]  t_strb [MaxEntries];
  logic [31:0] t_exp  [MaxEntries];
  logic        t_err  [MaxEntries];
  logic [31:0] ref_mem [256];

  int unsigned n_entries   = 0;
  int unsigned checks      = 0;
  int unsigned errors      = 0;
  int unsigned test_errors = 0;
  int unsigned cycles      = 0;
  integer      seed        = 32'he972e6be;

  string test_names [1:6] = '{"rom", "sram", "error regions", "clint", "debug delay",
                              "peripheral reset"};
  string pin_names [4] = '{"timer_irq_o", "ipi_o", "debug_req_o", "exit_o"};

  tb_clock_gen #(.Period(ClkPeriod), .ResetCycles(3)) i_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  soc_top uut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .rtc_i       ( rtc       ),
    .psel_i      ( psel      ),
    .penable_i   ( penable   ),
    .pwrite_i    ( pwrite    ),
    .paddr_i     ( paddr     ),
    .pwdata_i    ( pwdata    ),
    .pstrb_i     ( pstrb     ),
    .prdata_o    ( prdata    ),
    .pready_o    ( pready    ),
    .pslverr_o   ( pslverr   ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       ),
    .debug_req_o ( debug_req ),
    .exit_o      ( exit_code )
  );

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  task automatic apb_xfer(input logic write, input logic [15:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(negedge clk);
    penable = 1'b1;
    // Sample well inside the access cycle
    #(SampleDly);
    while (!pready) begin
      @(negedge clk);
      #(SampleDly);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Each pulse 8 cycles high, 8 low
  task automatic pulse_rtc(input int unsigned count);
    repeat (count) begin
      @(negedge clk);
      rtc = 1'b1;
      repeat (8) @(negedge clk);
      rtc = 1'b0;
      repeat (7) @(negedge clk);
    end
  endtask

  task automatic report_error(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic report_test(input int test);
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test, test_names[test]);
    end else begin
      $display("test %0d %s: %0d errors", test, test_names[test], test_errors);
    end
    test_errors = 0;
  endtask

  // --------------------------------------------------
  // Table construction
  // --------------------------------------------------
  task automatic push_entry(input int op, input int test, input logic [15:0] addr,
                            input logic [31:0] data, input logic [3:0] strb,
                            input logic [31:0] exp, input logic err);
    t_op[n_entries]   = op;
    t_test[n_entries] = test;
    t_addr[n_entries] = addr;
    t_data[n_entries] = data;
    t_strb[n_entries] = strb;
    t_exp[n_entries]  = exp;
    t_err[n_entries]  = err;
    n_entries++;
  endtask

  // Reference model merges strobed bytes as the write is staged
  task automatic stage_sram_write(input int unsigned idx, input logic [3:0] strb);
    logic [31:0] data;
    data = $random(seed);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    push_entry(OpWr, 2, SramBase + 16'(idx * 4), data, strb, '0, 1'b0);
  endtask

  task automatic expect_sram_word(input int test, input int unsigned idx);
    push_entry(OpRd, test, SramBase + 16'(idx * 4), '0, '0, ref_mem[idx], 1'b0);
  endtask

  task automatic build_table();
    int unsigned rom_idx [4]   = '{0, 1, 37, 63};
    int unsigned sram_idx [5]  = '{0, 1, 7, 100, 255};
    logic [3:0]  part_strb [5] = '{4'b0011, 4'b0001, 4'b0110, 4'b1000, 4'b0101};
    // Debug delay first, outputs quiet out of reset
    push_entry(OpPin, 5, PinTimer, '0, '0, 32'd0, 1'b0);
    push_entry(OpPin, 5, PinIpi, '0, '0, 32'd0, 1'b0);
    push_entry(OpPin, 5, PinExit, '0, '0, 32'd0, 1'b0);
    push_entry(OpWr, 5, DbgCtrl, 32'h2, 4'hF, '0, 1'b0);
    push_entry(OpRdNz, 5, DbgDelay, '0, '0, '0, 1'b0);
    push_entry(OpPin, 5, PinDbg, '0, '0, 32'd0, 1'b0);
    push_entry(OpPoll, 5, DbgDelay, '0, '0, 32'd0, 1'b0);
    push_entry(OpPin, 5, PinDbg, '0, '0, 32'd1, 1'b0);
    for (int i = 0; i < 4; i++) begin
      push_entry(OpRd, 1, RomBase + 16'(rom_idx[i] * 4), '0, '0,
                 {RomTagRef, 16'(rom_idx[i])}, 1'b0);
    end
    push_entry(OpWr, 1, RomBase, 32'h1234_5678, 4'hF, '0, 1'b1);
    for (int i = 0; i < 5; i++) begin
      stage_sram_write(sram_idx[i], 4'hF);
    end
    for (int i = 0; i < 5; i++) begin
      stage_sram_write(sram_idx[i], part_strb[i]);
    end
    for (int i = 0; i < 5; i++) begin
      expect_sram_word(2, sram_idx[i]);
    end
    // GPIO and region 0x9 answer with an error and zero data
    push_entry(OpRd, 3, 16'h3000, '0, '0, 32'd0, 1'b1);
    push_entry(OpWr, 3, 16'h3004, 32'hFFFF_FFFF, 4'hF, '0, 1'b1);
    push_entry(OpRd, 3, 16'h9010, '0, '0, 32'd0, 1'b1);
    push_entry(OpWr, 3, 16'h9000, 32'h0000_00A5, 4'hF, '0, 1'b1);
    push_entry(OpRd, 3, RomBase + 16'd20, '0, '0, {RomTagRef, 16'd5}, 1'b0);
    expect_sram_word(3, 7);
    push_entry(OpWr, 4, ClintMsip, 32'd1, 4'hF, '0, 1'b0);
    push_entry(OpPin, 4, PinIpi, '0, '0, 32'd1, 1'b0);
    push_entry(OpWr, 4, ClintMsip, 32'd0, 4'hF, '0, 1'b0);
    push_entry(OpPin, 4, PinIpi, '0, '0, 32'd0, 1'b0);
    push_entry(OpRd, 4, ClintTime, '0, '0, 32'd0, 1'b0);
    push_entry(OpRtc, 4, '0, 32'd5, '0, '0, 1'b0);
    push_entry(OpRd, 4, ClintTime, '0, '0, 32'd5, 1'b0);
    push_entry(OpWr, 4, ClintCmp, 32'd3, 4'hF, '0, 1'b0);
    push_entry(OpPin, 4, PinTimer, '0, '0, 32'd1, 1'b0);
    push_entry(OpWr, 4, ClintCmp, 32'd100, 4'hF, '0, 1'b0);
    push_entry(OpPin, 4, PinTimer, '0, '0, 32'd0, 1'b0);
    // Pulse ndmreset; CLINT returns to reset values, SRAM keeps its data
    push_entry(OpWr, 6, ClintMsip, 32'd1, 4'hF, '0, 1'b0);
    push_entry(OpPin, 6, PinIpi, '0, '0, 32'd1, 1'b0);
    push_entry(OpWr, 6, DbgCtrl, 32'h1, 4'hF, '0, 1'b0);
    push_entry(OpWr, 6, DbgCtrl, 32'h0, 4'hF, '0, 1'b0);
    push_entry(OpRd, 6, ClintMsip, '0, '0, 32'd0, 1'b0);
    push_entry(OpRd, 6, ClintTime, '0, '0, 32'd0, 1'b0);
    push_entry(OpRd, 6, ClintCmp, '0, '0, 32'hFFFF_FFFF, 1'b0);
    push_entry(OpPin, 6, PinIpi, '0, '0, 32'd0, 1'b0);
    expect_sram_word(6, 100);
    push_entry(OpWr, 6, DbgExit, 32'd1, 4'hF, '0, 1'b0);
    push_entry(OpPin, 6, PinExit, '0, '0, 32'd1, 1'b0);
  endtask

  // --------------------------------------------------
  // Entry execution
  // --------------------------------------------------
  task automatic run_entry(input int unsigned i);
    logic [31:0] rdata;
    logic        err;
    logic [31:0] pin;
    int unsigned polls;
    case (t_op[i])
      OpWr: begin
        apb_xfer(1'b1, t_addr[i], t_data[i], t_strb[i], rdata, err);
        checks++;
        if (err !== t_err[i]) begin
          report_error($sformatf("write %h: pslverr %b, expected %b", t_addr[i], err, t_err[i]));
        end
        // Read data stays zero on writes
        if (rdata !== t_exp[i]) begin
          report_error($sformatf("write %h: prdata %h, expected %h",
                                 t_addr[i], rdata, t_exp[i]));
        end
      end
      OpRd, OpRdNz, OpPoll: begin
        apb_xfer(1'b0, t_addr[i], '0, '0, rdata, err);
        // The boot window closes long before this many reads
        if (t_op[i] == OpPoll) begin
          polls = 0;
          while (rdata !== t_exp[i] && polls < DebugDelayCycles) begin
            apb_xfer(1'b0, t_addr[i], '0, '0, rdata, err);
            polls++;
          end
        end
        checks++;
        if (err !== t_err[i]) begin
          report_error($sformatf("read %h: pslverr %b, expected %b", t_addr[i], err, t_err[i]));
        end
        if (t_op[i] == OpRdNz) begin
          if (rdata === 32'd0 || $isunknown(rdata)) begin
            report_error($sformatf("read %h: got %h, expected nonzero", t_addr[i], rdata));
          end
        end else if (rdata !== t_exp[i]) begin
          report_error($sformatf("read %h: got %h, expected %h", t_addr[i], rdata, t_exp[i]));
        end
      end
      OpPin: begin
        case (t_addr[i])
          PinTimer: pin = {31'b0, timer_irq};
          PinIpi:   pin = {31'b0, ipi};
          PinDbg:   pin = {31'b0, debug_req};
          default:  pin = exit_code;
        endcase
        checks++;
        if (pin !== t_exp[i]) begin
          report_error($sformatf("%s is %h, expected %h", pin_names[t_addr[i]], pin, t_exp[i]));
        end
      end
      default: begin
        pulse_rtc(t_data[i]);
      end
    endcase
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    rtc     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    build_table();
    wait (rst_n === 1'b1);
    for (int unsigned i = 0; i < n_entries; i++) begin
      run_entry(i);
      if (i + 1 == n_entries || t_test[i + 1] != t_test[i]) begin
        report_test(t_test[i]);
      end
    end
    $display("%0d entries, %0d checks, %0d errors", n_entries, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/soc_pkg.sv
source/soc_apb_ctrl.sv
source/soc_rom.sv
source/soc_sram.sv
source/soc_clint.sv
source/soc_debug_unit.sv
source/soc_top.sv
tests/tb_clock_gen.sv
tests/soc_props.sv
tests/soc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f project.f
out=$(./obj_dir/Vsoc_tb)
echo "$out"
if grep -qxF ">>> PASS" <<< "$out"; then
  exit 0
else
  exit 1
fi
